// File: compile.f
hw/stream_pkg.sv
hw/dp_ram.sv
hw/sync_fifo.sv
hw/stream_ingress.sv
hw/stream_egress.sv
hw/stream_channel.sv
sim/tb_stream_channel.sv

// File: hw/dp_ram.sv
// dual-port memory with one synchronous write port and one registered read port
`timescale 1ns/1ps

module dp_ram
#(
   parameter int DW    = 40,                    // word width
   parameter int DEPTH = 16,                    // number of words
   parameter int AW    = $clog2(DEPTH)          // address width
)
(
   input  logic          clk,
   input  logic          wr_en,                 // write strobe
   input  logic [AW-1:0] wr_addr,               // write address
   input  logic [DW-1:0] wr_din,                // write data
   input  logic [AW-1:0] rd_addr,               // read address
   output logic [DW-1:0] rd_dout                // read data, one clock after address
);

   logic [DW-1:0] mem [DEPTH];                  // storage array

   // write port, whole words only
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_din;
      end
   end

   // read port, always enabled
   always_ff @(posedge clk)
   begin
      rd_dout <= mem[rd_addr];                  // registered output
   end

endmodule

// File: hw/stream_channel.sv
// buffered stream channel top joining ingress, FIFO storage and egress with fill status
`timescale 1ns/1ps

module stream_channel
#(
   parameter int DW        = stream_pkg::DATA_W, // payload width
   parameter int DEPTH     = 16,                 // FIFO memory words
   parameter int PROG_FULL = DEPTH/2,            // almost-full threshold
   localparam int AW       = $clog2(DEPTH)       // level width
)
(
   input  logic                     clk,
   input  logic                     nreset,      // sync, active low
   input  logic                     in_valid,
   output logic                     in_ready,
   input  stream_pkg::data_t        in_data,
   output logic                     out_valid,
   input  logic                     out_ready,
   output stream_pkg::stream_beat_t out_beat,
   output logic                     prog_full,   // FIFO almost full
   output logic [AW-1:0]            level        // FIFO entries
);

   import stream_pkg::*;

   logic         full;                           // FIFO full
   logic         empty;                          // FIFO empty
   logic         wr_en;                          // ingress -> FIFO
   logic         rd_en;                          // egress -> FIFO
   stream_beat_t wr_beat;                        // tagged beat in
   stream_beat_t rd_beat;                        // FIFO head out

   // payload type is fixed by the package
   if (DW != DATA_W)
   begin : g_dw_check
      $error("stream_channel: DW must equal stream_pkg::DATA_W");
   end

   stream_ingress u_ingress (
      .clk      (clk),
      .nreset   (nreset),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_data  (in_data),
      .full     (full),
      .wr_en    (wr_en),
      .wr_beat  (wr_beat)
   );

   sync_fifo #(
      .DW        (BEAT_W),
      .DEPTH     (DEPTH),
      .PROG_FULL (PROG_FULL),
      .AW        (AW)
   ) u_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .din       (wr_beat),
      .wr_en     (wr_en),
      .rd_en     (rd_en),
      .dout      (rd_beat),
      .full      (full),
      .prog_full (prog_full),
      .empty     (empty),
      .rd_count  (level)                         // fill level straight out
   );

   stream_egress u_egress (
      .clk       (clk),
      .nreset    (nreset),
      .empty     (empty),
      .rd_en     (rd_en),
      .rd_beat   (rd_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_beat  (out_beat)
   );

endmodule

// File: hw/stream_egress.sv
// egress stage that prefetches FIFO beats into two slots and drives the valid/ready output
`timescale 1ns/1ps

module stream_egress
(
   input  logic                     clk,
   input  logic                     nreset,     // sync, active low
   input  logic                     empty,      // FIFO empty
   output logic                     rd_en,      // FIFO read strobe
   input  stream_pkg::stream_beat_t rd_beat,    // FIFO head, registered
   output logic                     out_valid,  // beat on output
   input  logic                     out_ready,  // sink takes it
   output stream_pkg::stream_beat_t out_beat    // oldest slot
);

   import stream_pkg::*;

   typedef enum logic [1:0]
   {
      EG_EMPTY,                                 // no slot filled
      EG_ONE,                                   // one slot filled
      EG_TWO                                    // both slots filled
   } eg_state_t;

   eg_state_t    state;                         // slot occupancy
   eg_state_t    state_nxt;
   stream_beat_t slot [2];                      // prefetch buffer
   logic         head;                          // oldest slot
   logic         tail;                          // next slot to fill
   logic         inflight;                      // read issued last cycle
   logic         push;                          // FIFO data lands this cycle
   logic         pop;                           // output handshake
   logic         slot_free;                     // room counting the read in flight

   // ##############################
   // read issue and output
   // ##############################

   assign slot_free = (state == EG_EMPTY) || (state == EG_ONE && !inflight);
   assign rd_en     = ~empty & slot_free;
   assign push      = inflight;                 // one-cycle read latency
   assign out_valid = (state != EG_EMPTY);
   assign out_beat  = slot[head];
   assign pop       = out_valid & out_ready;

   // occupancy next state
   always_comb
   begin
      state_nxt = state;
      case (state)
         EG_EMPTY: if (push) state_nxt = EG_ONE;
         EG_ONE:
         begin
            if (push && !pop)
            begin
               state_nxt = EG_TWO;
            end
            else if (pop && !push)
            begin
               state_nxt = EG_EMPTY;
            end
         end
         EG_TWO:   if (pop) state_nxt = EG_ONE; // no read issued when full
         default:  state_nxt = EG_EMPTY;
      endcase
   end

   // ##############################
   // control registers
   // ##############################

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         state    <= EG_EMPTY;
         inflight <= 1'b0;
         head     <= 1'b0;
         tail     <= 1'b0;
      end
      else
      begin
         state    <= state_nxt;
         inflight <= rd_en;                     // FIFO never ignores it
         if (push)
         begin
            tail <= ~tail;
         end
         if (pop)
         begin
            head <= ~head;
         end
      end
   end

   // slot payload
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         slot[tail] <= rd_beat;                 // capture registered FIFO output
      end
   end

   // stalled beat stays put until taken
   a_out_stable: assert property (@(posedge clk) disable iff (!nreset)
      out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// File: hw/stream_ingress.sv
// ingress stage that accepts words by valid/ready and stamps each with a sequence tag
`timescale 1ns/1ps

module stream_ingress
(
   input  logic                     clk,
   input  logic                     nreset,     // sync, active low
   input  logic                     in_valid,   // source has a word
   output logic                     in_ready,   // room in FIFO
   input  stream_pkg::data_t        in_data,    // payload word
   input  logic                     full,       // FIFO full
   output logic                     wr_en,      // FIFO write strobe
   output stream_pkg::stream_beat_t wr_beat     // tagged beat to FIFO
);

   import stream_pkg::*;

   seq_t seq_cnt;                               // tag for the next accepted word

   // ##############################
   // handshake
   // ##############################

   assign in_ready = ~full;                     // ready straight from FIFO
   assign wr_en    = in_valid & ~full;          // accept = write, same cycle

   // pack payload and tag
   assign wr_beat.data = in_data;
   assign wr_beat.seq  = seq_cnt;

   // ##############################
   // sequence counter
   // ##############################

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         seq_cnt <= '0;                         // first word gets tag 0
      end
      else if (wr_en)
      begin
         seq_cnt <= seq_cnt + 1'b1;             // wraps after 255
      end
   end

endmodule

// File: hw/stream_pkg.sv
// stream channel package with payload and tag widths, vector types and the stored beat

package stream_pkg;

   // ##############################
   // widths
   // ##############################

   localparam int DATA_W = 32;                  // payload word width
   localparam int SEQ_W  = 8;                   // sequence tag width, wraps mod 256

   // ##############################
   // vector types
   // ##############################

   typedef logic [DATA_W-1:0] data_t;           // payload word
   typedef logic [SEQ_W-1:0]  seq_t;            // sequence tag

   // ##############################
   // beat
   // ##############################

   // one tagged word, as stored in the FIFO and sent out
   typedef struct packed
   {
      data_t data;                              // payload
      seq_t  seq;                               // stamp given at ingress
   } stream_beat_t;

   localparam int BEAT_W = $bits(stream_beat_t); // FIFO word width

endpackage

// File: hw/sync_fifo.sv
// synchronous FIFO with entry count, full, almost-full and empty flags over dp_ram
`timescale 1ns/1ps

module sync_fifo
#(
   parameter int DW        = 40,                // entry width
   parameter int DEPTH     = 16,                // memory words
   parameter int PROG_FULL = DEPTH/2,           // almost-full threshold
   parameter int AW        = $clog2(DEPTH)      // pointer and count width
)
(
   input  logic          clk,
   input  logic          nreset,                // sync, active low
   input  logic [DW-1:0] din,                   // write data
   input  logic          wr_en,                 // write request
   input  logic          rd_en,                 // read request
   output logic [DW-1:0] dout,                  // head entry, registered
   output logic          full,                  // at DEPTH-1 entries
   output logic          prog_full,             // count at or above threshold
   output logic          empty,                 // no entries
   output logic [AW-1:0] rd_count               // entries held
);

   logic [AW-1:0] wr_addr;                      // write pointer
   logic [AW-1:0] rd_addr;                      // read pointer
   logic          fifo_write;                   // qualified write
   logic          fifo_read;                    // qualified read

   // ##############################
   // flags and strobes
   // ##############################

   assign empty      = (rd_count == '0);
   assign full       = (rd_count == AW'(DEPTH-1)); // one word kept free
   assign prog_full  = (rd_count >= AW'(PROG_FULL));
   assign fifo_write = wr_en & ~full;           // drop writes when full
   assign fifo_read  = rd_en & ~empty;          // drop reads when empty

   // ##############################
   // pointers and count
   // ##############################

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         wr_addr  <= '0;
         rd_addr  <= '0;
         rd_count <= '0;
      end
      else
      begin
         if (fifo_write)
         begin
            wr_addr <= wr_addr + 1'b1;          // wraps at DEPTH
         end
         if (fifo_read)
         begin
            rd_addr <= rd_addr + 1'b1;
         end
         if (fifo_write && !fifo_read)
         begin
            rd_count <= rd_count + 1'b1;
         end
         else if (fifo_read && !fifo_write)
         begin
            rd_count <= rd_count - 1'b1;
         end                                    // both or neither: count held
      end
   end

   dp_ram #(
      .DW    (DW),
      .DEPTH (DEPTH),
      .AW    (AW)
   ) u_mem (
      .clk     (clk),
      .wr_en   (fifo_write),
      .wr_addr (wr_addr),
      .wr_din  (din),
      .rd_addr (rd_addr),                       // head address, read every cycle
      .rd_dout (dout)
   );

   // count holds at the cap instead of wrapping when a write is refused
   a_no_overflow: assert property (@(posedge clk) disable iff (!nreset)
      full && !fifo_read |=> rd_count == AW'(DEPTH-1));

   // without a write an empty FIFO stays at zero
   a_empty_holds: assert property (@(posedge clk) disable iff (!nreset)
      empty && !wr_en |=> rd_count == '0);

endmodule

// File: run.sh
#!/bin/sh
# build and run the stream channel testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
   --top-module tb_stream_channel -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1

// File: sim/tb_stream_channel.sv
// testbench for the stream channel, table-driven traffic checked against a reference queue
`timescale 1ns/1ps

module tb_stream_channel;

   import stream_pkg::*;

   localparam int DEPTH     = 16;               // FIFO memory words
   localparam int PROG_FULL = DEPTH/2;          // almost-full threshold
   localparam int AW        = $clog2(DEPTH);    // level width
   localparam int N_ROWS    = 6;

   typedef enum logic [1:0]
   {
      ROW_RUN,                                  // run until all words accepted
      ROW_FILL,                                 // sink stalled, run until in_ready drops
      ROW_DRAIN                                 // run until every beat has left
   } row_mode_t;

   typedef struct packed
   {
      int        words;                         // words offered
      int        valid_pct;                     // chance of in_valid per cycle
      int        ready_pct;                     // chance of out_ready per cycle
      row_mode_t mode;
   } row_t;

   // ##############################
   // stimulus table
   // ##############################

   row_t rows [N_ROWS] = '{
      '{40,   100, 0,   ROW_FILL},              // back-pressure, fill to capacity
      '{0,    0,   100, ROW_DRAIN},             // release sink, empty out
      '{300,  100, 100, ROW_RUN},               // full rate, tag wraps here
      '{1000, 60,  50,  ROW_RUN},               // random traffic
      '{200,  90,  20,  ROW_RUN},               // mostly stalled sink
      '{0,    0,   100, ROW_DRAIN}              // final drain
   };

   logic                clk;
   logic                nreset;
   logic                in_valid;
   logic                in_ready;
   data_t               in_data;
   logic                out_valid;
   logic                out_ready;
   stream_beat_t        out_beat;
   logic                prog_full;
   logic [AW-1:0]       level;

   stream_beat_t        ref_q [$];              // beats accepted, not yet out
   seq_t                model_seq;              // tag of next accepted word
   logic                cur_valid;              // source holds a word
   data_t               cur_data;
   int                  n_beat_err;
   int                  n_level_err;
   int                  n_status_err;
   int                  n_proto_err;

   stream_channel #(
      .DEPTH     (DEPTH),
      .PROG_FULL (PROG_FULL)
   ) i_dut (
      .clk       (clk),
      .nreset    (nreset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_beat  (out_beat),
      .prog_full (prog_full),
      .level     (level)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;                   // 100 ns period
   end

   // ##############################
   // compare tasks
   // ##############################

   task automatic check_beat(input stream_beat_t got, input stream_beat_t expected);
      if (got !== expected)
      begin
         $display("FAILED %0t: beat got data %h seq %0d, expected data %h seq %0d",
                  $time, got.data, got.seq, expected.data, expected.seq);
         n_beat_err++;
      end
   endtask

   task automatic check_level(input logic got_prog_full, input logic [AW-1:0] count);
      logic exp_pf;
      exp_pf = (count >= AW'(PROG_FULL));       // flag follows level
      if (got_prog_full !== exp_pf)
      begin
         $display("FAILED %0t: prog_full %b at level %0d, expected %b",
                  $time, got_prog_full, count, exp_pf);
         n_level_err++;
      end
   endtask

   task automatic check_count(input string what, input logic [AW-1:0] got,
                              input logic [AW-1:0] expected);
      if (got !== expected)
      begin
         $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, expected);
         n_status_err++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic expected);
      if (got !== expected)
      begin
         $display("FAILED %0t: %s is %b, expected %b", $time, what, got, expected);
         n_status_err++;
      end
   endtask

   // ##############################
   // cycle tasks
   // ##############################

   // inputs change just after the edge
   task automatic drive_cycle(input logic v, input data_t d, input logic r);
      @(posedge clk);
      #10;
      in_valid  = v;
      in_data   = d;
      out_ready = r;
   endtask

   // mid-cycle sample, both handshakes complete on the next edge
   task automatic sample_cycle(output logic accepted);
      stream_beat_t beat;
      @(negedge clk);
      accepted = in_valid && in_ready;
      if (accepted)
      begin
         beat.data = in_data;
         beat.seq  = model_seq;                 // count of earlier words, mod 256
         ref_q.push_back(beat);
         model_seq = model_seq + seq_t'(1);
      end
      if (out_valid && out_ready)
      begin
         if (ref_q.size() == 0)
         begin
            $display("output beat at %0t with no word outstanding", $time);
            n_proto_err++;
         end
         else
         begin
            beat = ref_q.pop_front();
            check_beat(out_beat, beat);
         end
      end
      check_level(prog_full, level);            // every cycle
   endtask

   task automatic run_row(input row_t row);
      int   acc_cnt;
      logic acc;
      logic stalled;
      logic rdy;
      acc_cnt = 0;
      stalled = 1'b0;
      while ((acc_cnt < row.words && !stalled) ||
             (row.mode == ROW_DRAIN && ref_q.size() > 0))
      begin
         if (!cur_valid && acc_cnt < row.words)
         begin
            cur_valid = ($urandom_range(99) < row.valid_pct);
            if (cur_valid)
            begin
               cur_data = $urandom;             // new word only after accept
            end
         end
         rdy = ($urandom_range(99) < row.ready_pct);
         drive_cycle(cur_valid, cur_data, rdy);
         sample_cycle(acc);
         if (acc)
         begin
            acc_cnt++;
            cur_valid = 1'b0;
         end
         else if (row.mode == ROW_FILL && !in_ready)
         begin
            stalled = 1'b1;
         end
      end
      if (row.mode == ROW_FILL)
      begin
         if (!stalled)
         begin
            $display("in_ready never dropped with the sink stalled");
            n_proto_err++;
         end
         if (acc_cnt != DEPTH + 1)
         begin
            $display("FAILED %0t: %0d words accepted before stall, expected %0d",
                     $time, acc_cnt, DEPTH + 1);
            n_status_err++;
         end
         check_count("level at stall", level, AW'(DEPTH - 1));
         check_flag("prog_full at stall", prog_full, 1'b1);
         cur_valid = 1'b0;                      // withdraw the refused word
      end
      if (row.mode == ROW_DRAIN)
      begin
         drive_cycle(1'b0, cur_data, 1'b1);     // let the last beat leave
         sample_cycle(acc);
         check_flag("in_ready after drain", in_ready, 1'b1);
         check_flag("out_valid after drain", out_valid, 1'b0);
         check_count("level after drain", level, '0);
         check_flag("prog_full after drain", prog_full, 1'b0);
      end
   endtask

   // ##############################
   // main sequence
   // ##############################

   initial
   begin
      nreset       = 1'b0;
      in_valid     = 1'b0;
      in_data      = '0;
      out_ready    = 1'b0;
      cur_valid    = 1'b0;
      cur_data     = '0;
      model_seq    = '0;
      n_beat_err   = 0;
      n_level_err  = 0;
      n_status_err = 0;
      n_proto_err  = 0;
      void'($urandom(32'h85e4a512));            // fixed seed
      repeat (10) @(posedge clk);
      #10;
      nreset = 1'b1;
      @(negedge clk);
      check_flag("in_ready after reset", in_ready, 1'b1);
      check_flag("out_valid after reset", out_valid, 1'b0);
      check_count("level after reset", level, '0);
      check_flag("prog_full after reset", prog_full, 1'b0);
      for (int i = 0; i < N_ROWS; i++)
      begin
         run_row(rows[i]);
      end
      if (ref_q.size() != 0)
      begin
         $display("%0d accepted words never came out", ref_q.size());
         n_proto_err++;
      end
      $display("errors: beat %0d, level %0d, status %0d, protocol %0d",
               n_beat_err, n_level_err, n_status_err, n_proto_err);
      if (n_beat_err + n_level_err + n_status_err + n_proto_err == 0)
      begin
         $display("All checks passed");
      end
      else
      begin
         $display("Checks failed");
      end
      $finish;
   end

   // watchdog, 20 cycles per word plus slack
   initial
   begin : watchdog
      int limit;
      limit = 1000;
      for (int i = 0; i < N_ROWS; i++)
      begin
         limit = limit + rows[i].words * 20;
      end
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Checks failed");
      $finish;
   end

endmodule
